/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cpu_top
FILELIST  = cpu_top.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check the log for the pass line"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////
// Core widths
//////////////////////////////

// Data and register width
`define XLEN 64

// Register index width and count
`define REG_ADDR_W 5
`define REG_NUM 32

//////////////////////////////
// Reset state
//////////////////////////////

// First fetch address
`define PC_RESET 64'h0000_0000_0000_1000

`endif

/* cpu_top.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_pc.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_apb_lsu.sv
cpu_top.sv
tb_cpu_top.sv

/* cpu_top.sv */
`include "cpu_defines.svh"

module cpu_top (
    input  logic             sys_clk,
    input  logic             rst,
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready,
    output logic [`XLEN-1:0] paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    output logic             halted
);
    logic [`XLEN-1:0]       pc_seq, imm, rs1_data, rs2_data, alu_out, load_data, wr_data;
    logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    rv_isa_pkg::alu_op_e    alu_op;
    rv_ctrl_pkg::op1_sel_e  op1_sel;
    rv_ctrl_pkg::op2_sel_e  op2_sel;
    rv_ctrl_pkg::npc_sel_e  npc_sel;
    rv_ctrl_pkg::wb_sel_e   wb_sel;
    logic                   reg_wen, mem_req, mem_write, is_halt, stall;

    // Write-back select
    always_comb begin
        case (wb_sel)
            rv_ctrl_pkg::WB_MEM:    wr_data = load_data;
            rv_ctrl_pkg::WB_PC_SEQ: wr_data = pc_seq;
            default:                wr_data = alu_out;
        endcase
    end

    rv_pc pc_e (
        .sys_clk(sys_clk), .rst(rst), .npc_sel(npc_sel), .alu_out(alu_out),
        .stall(stall), .is_halt(is_halt), .pc(pc), .pc_seq(pc_seq), .halted(halted)
    );

    rv_decoder decoder_e (
        .inst(inst), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr), .imm(imm),
        .alu_op(alu_op), .op1_sel(op1_sel), .op2_sel(op2_sel), .npc_sel(npc_sel),
        .wb_sel(wb_sel), .reg_wen(reg_wen), .mem_req(mem_req), .mem_write(mem_write),
        .is_halt(is_halt)
    );

    // No register write until the memory access has finished
    rv_regfile regfile_e (
        .sys_clk(sys_clk), .rst(rst), .wen(reg_wen && !stall), .rd_addr(rd_addr),
        .wr_data(wr_data), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_alu alu_e (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm(imm),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .alu_op(alu_op), .alu_out(alu_out)
    );

    rv_apb_lsu lsu_e (
        .sys_clk(sys_clk), .rst(rst), .mem_req(mem_req), .mem_write(mem_write),
        .addr(alu_out), .wdata(rs2_data), .prdata(prdata), .pready(pready),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .stall(stall), .load_data(load_data)
    );

endmodule

/* rv_alu.sv */
`include "cpu_defines.svh"

module rv_alu (
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm,
    input  rv_ctrl_pkg::op1_sel_e op1_sel,
    input  rv_ctrl_pkg::op2_sel_e op2_sel,
    input  rv_isa_pkg::alu_op_e   alu_op,
    output logic [`XLEN-1:0]      alu_out
);
    logic [`XLEN-1:0] op_a, op_b;
    logic [5:0]       shamt;

    //////////////////////////////
    // Operand select
    //////////////////////////////
    always_comb begin
        case (op1_sel)
            rv_ctrl_pkg::OP1_PC:   op_a = pc;
            rv_ctrl_pkg::OP1_ZERO: op_a = '0;
            default:               op_a = rs1_data;
        endcase
    end

    always_comb begin
        case (op2_sel)
            rv_ctrl_pkg::OP2_RS2: op_b = rs2_data;
            default:              op_b = imm;
        endcase
    end

    // RV64 shift amount
    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_op)
            rv_isa_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_isa_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_isa_pkg::ALU_SLT:    alu_out = `XLEN'($signed(op_a) < $signed(op_b));
            rv_isa_pkg::ALU_SLTU:   alu_out = `XLEN'(op_a < op_b);
            rv_isa_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_isa_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_isa_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_isa_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_isa_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_isa_pkg::ALU_PASS_B: alu_out = op_b;
            default:                alu_out = op_a + op_b;
        endcase
    end

endmodule

/* rv_apb_lsu.sv */
`include "cpu_defines.svh"

module rv_apb_lsu (
    input  logic             sys_clk,
    input  logic             rst,
    input  logic             mem_req,
    input  logic             mem_write,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready,
    output logic [`XLEN-1:0] paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    output logic             stall,
    output logic [`XLEN-1:0] load_data
);
    rv_ctrl_pkg::lsu_state_e state_q, state_d, phase;
    logic [`XLEN-1:0]        addr_q, wdata_q;
    logic                    write_q;

    // A request seen in idle makes this cycle the APB setup cycle
    assign phase = (state_q == rv_ctrl_pkg::LSU_IDLE && mem_req) ? rv_ctrl_pkg::LSU_SETUP
                                                                  : state_q;

    always_comb begin
        state_d = state_q;
        case (phase)
            rv_ctrl_pkg::LSU_SETUP:  state_d = rv_ctrl_pkg::LSU_ACCESS;
            rv_ctrl_pkg::LSU_ACCESS: if (pready) state_d = rv_ctrl_pkg::LSU_DONE;
            default:                 state_d = rv_ctrl_pkg::LSU_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst)
            state_q <= rv_ctrl_pkg::LSU_IDLE;
        else
            state_q <= state_d;
    end

    // Transfer fields held from setup until the end of access
    always_ff @(posedge sys_clk) begin
        if (phase == rv_ctrl_pkg::LSU_SETUP) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            write_q <= mem_write;
        end
        if (phase == rv_ctrl_pkg::LSU_ACCESS && pready)
            load_data <= prdata;
    end

    //////////////////////////////
    // APB outputs
    //////////////////////////////
    assign psel    = phase == rv_ctrl_pkg::LSU_SETUP || phase == rv_ctrl_pkg::LSU_ACCESS;
    assign penable = phase == rv_ctrl_pkg::LSU_ACCESS;
    assign pwrite  = (phase == rv_ctrl_pkg::LSU_SETUP) ? mem_write : (penable && write_q);
    assign paddr   = (phase == rv_ctrl_pkg::LSU_SETUP) ? addr : addr_q;
    assign pwdata  = (phase == rv_ctrl_pkg::LSU_SETUP) ? wdata : wdata_q;

    // Release in done so the load is written back
    assign stall = mem_req && phase != rv_ctrl_pkg::LSU_DONE;

    // Access only inside a transfer that was already selected a cycle earlier
    apb_enable_in_select: assert property (
        @(posedge sys_clk) disable iff (rst) penable |-> psel && $past(psel));

    apb_addr_stable: assert property (
        @(posedge sys_clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // Next pc source
    typedef enum logic [1:0] {NPC_SEQ, NPC_ALU, NPC_ALU_CLR} npc_sel_e;

    // Register write-back source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_SEQ} wb_sel_e;

    // ALU operand a
    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;

    // ALU operand b
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;

    // Load-store unit, one APB transfer per request
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_SETUP,
        LSU_ACCESS,
        LSU_DONE
    } lsu_state_e;

endpackage

/* rv_decoder.sv */
`include "cpu_defines.svh"

module rv_decoder (
    input  logic [31:0]             inst,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic [`REG_ADDR_W-1:0]  rd_addr,
    output logic [`XLEN-1:0]        imm,
    output rv_isa_pkg::alu_op_e     alu_op,
    output rv_ctrl_pkg::op1_sel_e   op1_sel,
    output rv_ctrl_pkg::op2_sel_e   op2_sel,
    output rv_ctrl_pkg::npc_sel_e   npc_sel,
    output rv_ctrl_pkg::wb_sel_e    wb_sel,
    output logic                    reg_wen,
    output logic                    mem_req,
    output logic                    mem_write,
    output logic                    is_halt
);
    logic [2:0]       funct3;
    logic             alt;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic             eq, lt, ltu, taken;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    // funct7 bit 5, selects SUB and SRA
    assign alt      = inst[30];

    //////////////////////////////
    // Immediates
    //////////////////////////////
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    //////////////////////////////
    // Branch resolution
    //////////////////////////////
    assign eq  = rs1_data == rs2_data;
    assign lt  = $signed(rs1_data) < $signed(rs2_data);
    assign ltu = rs1_data < rs2_data;

    always_comb begin
        case (rv_isa_pkg::branch_e'(funct3))
            rv_isa_pkg::BR_EQ:  taken = eq;
            rv_isa_pkg::BR_NE:  taken = !eq;
            rv_isa_pkg::BR_LT:  taken = lt;
            rv_isa_pkg::BR_GE:  taken = !lt;
            rv_isa_pkg::BR_LTU: taken = ltu;
            rv_isa_pkg::BR_GEU: taken = !ltu;
            default:            taken = 1'b0;
        endcase
    end

    // OP and OP-IMM share funct3; only OP has SUB
    function automatic rv_isa_pkg::alu_op_e alu_func(logic [2:0] f3, logic sub_sra, logic is_op);
        case (f3)
            3'b000:  return (is_op && sub_sra) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001:  return rv_isa_pkg::ALU_SLL;
            3'b010:  return rv_isa_pkg::ALU_SLT;
            3'b011:  return rv_isa_pkg::ALU_SLTU;
            3'b100:  return rv_isa_pkg::ALU_XOR;
            3'b101:  return sub_sra ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  return rv_isa_pkg::ALU_OR;
            default: return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    //////////////////////////////
    // Control selects
    //////////////////////////////
    always_comb begin
        // No-op unless an opcode below matches
        imm = imm_i;
        alu_op = rv_isa_pkg::ALU_ADD;
        op1_sel = rv_ctrl_pkg::OP1_RS1;
        op2_sel = rv_ctrl_pkg::OP2_IMM;
        npc_sel = rv_ctrl_pkg::NPC_SEQ;
        wb_sel = rv_ctrl_pkg::WB_ALU;
        reg_wen = 1'b0;
        mem_req = 1'b0;
        mem_write = 1'b0;
        is_halt = 1'b0;
        case (rv_isa_pkg::opcode_e'(inst[6:0]))
            rv_isa_pkg::OPC_LUI: begin
                imm = imm_u;
                op1_sel = rv_ctrl_pkg::OP1_ZERO;
                alu_op = rv_isa_pkg::ALU_PASS_B;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                imm = imm_u;
                op1_sel = rv_ctrl_pkg::OP1_PC;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                imm = imm_j;
                op1_sel = rv_ctrl_pkg::OP1_PC;
                npc_sel = rv_ctrl_pkg::NPC_ALU;
                wb_sel = rv_ctrl_pkg::WB_PC_SEQ;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                npc_sel = rv_ctrl_pkg::NPC_ALU_CLR;
                wb_sel = rv_ctrl_pkg::WB_PC_SEQ;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm = imm_b;
                op1_sel = rv_ctrl_pkg::OP1_PC;
                npc_sel = taken ? rv_ctrl_pkg::NPC_ALU : rv_ctrl_pkg::NPC_SEQ;
            end
            rv_isa_pkg::OPC_LOAD: begin
                // LD only
                mem_req = funct3 == 3'b011;
                wb_sel = rv_ctrl_pkg::WB_MEM;
                reg_wen = funct3 == 3'b011;
            end
            rv_isa_pkg::OPC_STORE: begin
                imm = imm_s;
                mem_req = funct3 == 3'b011;
                mem_write = funct3 == 3'b011;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                alu_op = alu_func(funct3, alt, 1'b0);
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_OP: begin
                op2_sel = rv_ctrl_pkg::OP2_RS2;
                alu_op = alu_func(funct3, alt, 1'b1);
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_SYSTEM: is_halt = inst == 32'h0010_0073;
            default: ;
        endcase
    end

    // Fetch stays word aligned and a store never writes a register
    decode_sane: assert final ($isunknown({inst, pc})
        || (pc[1:0] == 2'b00 && !(reg_wen && mem_write)));

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Branch conditions, funct3 of BRANCH
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

endpackage

/* rv_pc.sv */
`include "cpu_defines.svh"

module rv_pc (
    input  logic                  sys_clk,
    input  logic                  rst,
    input  rv_ctrl_pkg::npc_sel_e npc_sel,
    input  logic [`XLEN-1:0]      alu_out,
    input  logic                  stall,
    input  logic                  is_halt,
    output logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      pc_seq,
    output logic                  halted
);
    logic [`XLEN-1:0] pc_next;

    assign pc_seq = pc + `XLEN'(4);

    always_comb begin
        case (npc_sel)
            rv_ctrl_pkg::NPC_ALU:     pc_next = alu_out;
            // JALR target drops bit 0
            rv_ctrl_pkg::NPC_ALU_CLR: pc_next = {alu_out[`XLEN-1:1], 1'b0};
            default:                  pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            pc     <= `PC_RESET;
            halted <= 1'b0;
        end else begin
            if (is_halt)
                halted <= 1'b1;
            // Hold on an open transfer and at EBREAK
            if (!(stall || is_halt || halted))
                pc <= pc_next;
        end
    end

    // Held pc keeps fetching the EBREAK that halted the core
    pc_frozen_when_halted: assert property (
        @(posedge sys_clk) disable iff (rst) halted |=> $stable(pc) && is_halt);

endmodule

/* rv_regfile.sv */
`include "cpu_defines.svh"

module rv_regfile (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic [`XLEN-1:0]       wr_data,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);
    logic [`XLEN-1:0] regs [`REG_NUM];

    // Combinational reads
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++)
                regs[i] <= '0;
        end else if (wen && rd_addr != '0) begin
            // x0 is never written so it reads zero
            regs[rd_addr] <= wr_data;
        end
    end

endmodule

/* tb_cpu_top.sv */
`include "cpu_defines.svh"

module tb_cpu_top;

    logic             sys_clk;
    logic             rst;
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] prdata;
    logic             pready;
    logic [`XLEN-1:0] paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [`XLEN-1:0] pwdata;
    logic             halted;

    // Program ROM and APB data memory
    logic [31:0]      rom [0:127];
    int               rom_len;
    logic [`XLEN-1:0] mem [0:63];
    integer           seed;
    int               waits;

    // ISA reference model state
    logic [`XLEN-1:0] model_regs [0:31];
    logic [`XLEN-1:0] model_mem [0:63];
    logic             model_halt;

    // APB writes seen by the slave, in order
    logic [`XLEN-1:0] wr_addr_q [$];
    logic [`XLEN-1:0] wr_data_q [$];

    logic [`XLEN-1:0] prev_pc;
    logic [`XLEN-1:0] phase3_pc;
    logic [`XLEN-1:0] phase4_pc;
    logic [`XLEN-1:0] ebreak_pc;
    logic             running;
    logic             halt_seen;
    int               checks [1:5];
    int               errors [1:5];
    string            names [1:5];

    cpu_top i_cpu_top (
        .sys_clk(sys_clk), .rst(rst), .inst(inst), .pc(pc),
        .prdata(prdata), .pready(pready), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .halted(halted)
    );

    always #10 sys_clk = ~sys_clk;

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    // SD only
    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
                                           input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd, input int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic put(input logic [31:0] w);
        rom[rom_len] = w;
        rom_len++;
    endtask

    function automatic logic [31:0] fetch(input logic [`XLEN-1:0] a);
        if (a >= `PC_RESET && a < `PC_RESET + 64'd512)
            return rom[a[8:2]];
        return 32'h0000_0013;
    endfunction

    function automatic int mem_idx(input logic [`XLEN-1:0] a);
        return int'(a[8:3]);
    endfunction

    always_comb inst = fetch(pc);

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction on the model; returns the next pc
    function automatic logic [`XLEN-1:0] ref_step(input logic [`XLEN-1:0] cpc,
                                                  input logic [31:0] ins,
                                                  output logic st_v,
                                                  output logic [`XLEN-1:0] st_a,
                                                  output logic [`XLEN-1:0] st_d);
        logic [2:0]       f3;
        logic [4:0]       rd;
        logic [`XLEN-1:0] a, b, ii, is, ib, iu, ij, npc, res;
        logic             wr, tk;
        f3 = ins[14:12];
        rd = ins[11:7];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        ii = {{52{ins[31]}}, ins[31:20]};
        is = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        ib = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        iu = {{32{ins[31]}}, ins[31:12], 12'b0};
        ij = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc = cpc + 64'd4;
        res = '0;
        wr = 1'b0;
        tk = 1'b0;
        st_v = 1'b0;
        st_a = '0;
        st_d = '0;
        case (ins[6:0])
            7'h37: begin
                res = iu;
                wr = 1'b1;
            end
            7'h17: begin
                res = cpc + iu;
                wr = 1'b1;
            end
            7'h6f: begin
                res = cpc + 64'd4;
                wr = 1'b1;
                npc = cpc + ij;
            end
            7'h67: begin
                res = cpc + 64'd4;
                wr = 1'b1;
                npc = (a + ii) & ~64'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0:    tk = a == b;
                    3'd1:    tk = a != b;
                    3'd4:    tk = $signed(a) < $signed(b);
                    3'd5:    tk = $signed(a) >= $signed(b);
                    3'd6:    tk = a < b;
                    3'd7:    tk = a >= b;
                    default: tk = 1'b0;
                endcase
                if (tk)
                    npc = cpc + ib;
            end
            7'h03: if (f3 == 3'd3) begin
                res = model_mem[mem_idx(a + ii)];
                wr = 1'b1;
            end
            7'h23: if (f3 == 3'd3) begin
                st_v = 1'b1;
                st_a = a + is;
                st_d = b;
                model_mem[mem_idx(st_a)] = b;
            end
            7'h13: begin
                res = alu_ref(f3, f3 == 3'd5 && ins[30], a, ii);
                wr = 1'b1;
            end
            7'h33: begin
                res = alu_ref(f3, ins[30], a, b);
                wr = 1'b1;
            end
            7'h73: if (ins == 32'h0010_0073) begin
                model_halt = 1'b1;
                npc = cpc;
            end
            default: ;
        endcase
        if (wr && rd != 5'd0)
            model_regs[rd] = res;
        return npc;
    endfunction

    task automatic check(input int t, input logic ok, input string msg);
        assert (ok) checks[t]++;
        else begin
            errors[t]++;
            $display("ERR @%0t: %s", $time, msg);
        end
    endtask

    task automatic report_test(input int t);
        if (errors[t] == 0)
            $display("test %0d %s: ok, %0d checks", t, names[t], checks[t]);
        else
            $display("test %0d %s: %0d of %0d checks failed", t, names[t], errors[t],
                     checks[t] + errors[t]);
    endtask

    function automatic int test_of(input logic [`XLEN-1:0] a, input logic [31:0] ins);
        if (ins[6:0] == 7'h63 || ins[6:0] == 7'h6f || ins[6:0] == 7'h67)
            return 3;
        if (a < phase3_pc)
            return 2;
        if (a < phase4_pc)
            return 3;
        return 4;
    endfunction

    //////////////////////////////
    // APB slave
    //////////////////////////////
    always begin : apb_slave
        @(posedge sys_clk);
        #1;
        if (rst) begin
            pready = 1'b0;
        end else if (psel && !penable) begin
            waits = $random(seed) & 3;
            pready = 1'b0;
        end else if (psel && penable) begin
            if (waits == 0) begin
                pready = 1'b1;
                prdata = mem[mem_idx(paddr)];
                if (pwrite) begin
                    mem[mem_idx(paddr)] = pwdata;
                    wr_addr_q.push_back(paddr);
                    wr_data_q.push_back(pwdata);
                end
            end else begin
                waits--;
                pready = 1'b0;
            end
        end else begin
            pready = 1'b0;
        end
    end

    //////////////////////////////
    // Compare against the model
    //////////////////////////////
    always begin : compare_proc
        logic [`XLEN-1:0] exp_pc, sa, sd, got_a, got_d;
        logic             sv;
        logic [31:0]      ins;
        int               t;
        @(posedge sys_clk);
        #5;
        if (running && !halt_seen) begin
            if (psel && penable)
                check(4, pc == prev_pc, $sformatf("pc moved to %h during APB transfer", pc));
            ins = fetch(prev_pc);
            if (halted) begin
                halt_seen = 1'b1;
                exp_pc = ref_step(prev_pc, ins, sv, sa, sd);
                check(5, model_halt && pc == ebreak_pc && exp_pc == pc,
                      $sformatf("halt at pc %h, EBREAK is at %h", pc, ebreak_pc));
            end else if (pc != prev_pc) begin
                t = test_of(prev_pc, ins);
                exp_pc = ref_step(prev_pc, ins, sv, sa, sd);
                check(t, pc == exp_pc,
                      $sformatf("pc %h after %h, expected %h", pc, prev_pc, exp_pc));
                if (sv) begin
                    check(t, wr_addr_q.size() > 0,
                          $sformatf("no APB write for the store at %h", prev_pc));
                    if (wr_addr_q.size() > 0) begin
                        got_a = wr_addr_q.pop_front();
                        got_d = wr_data_q.pop_front();
                        check(t, got_a == sa && got_d == sd,
                              $sformatf("store %h=%h, expected %h=%h", got_a, got_d, sa, sd));
                    end
                end
            end
            prev_pc = pc;
        end
    end

    //////////////////////////////
    // Stimulus and run control
    //////////////////////////////
    initial begin : main
        int cyc;
        int total_chk;
        int total_err;
        sys_clk = 1'b0;
        rst = 1'b1;
        pready = 1'b0;
        prdata = '0;
        seed = 85;
        running = 1'b0;
        halt_seen = 1'b0;
        model_halt = 1'b0;
        names[1] = "reset state";
        names[2] = "alu and immediates";
        names[3] = "branches and jumps";
        names[4] = "loads under wait states";
        names[5] = "halt";
        for (int i = 1; i <= 5; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {$random(seed), $random(seed)};
            model_mem[i] = mem[i];
        end
        for (int i = 0; i < 128; i++)
            rom[i] = 32'h0000_0013;
        rom_len = 0;

        // ALU results stored from 0x2000 upward
        put(u_type(2, 1, 'h37));
        put(i_type(-5, 0, 0, 2, 'h13));
        put(i_type(12, 0, 0, 3, 'h13));
        put(r_type(0, 3, 2, 0, 4));
        put(r_type('h20, 3, 2, 0, 5));
        put(r_type(0, 3, 2, 2, 6));
        put(r_type(0, 3, 2, 3, 7));
        put(r_type(0, 3, 2, 4, 8));
        put(r_type(0, 3, 2, 1, 9));
        put(r_type(0, 3, 2, 5, 10));
        put(r_type('h20, 3, 2, 5, 11));
        put(r_type(0, 3, 2, 6, 12));
        put(r_type(0, 3, 2, 7, 13));
        put(i_type(40, 2, 1, 14, 'h13));
        put(i_type(3, 2, 5, 15, 'h13));
        put(i_type(1027, 2, 5, 16, 'h13));
        put(i_type(-4, 2, 2, 17, 'h13));
        put(i_type(13, 3, 3, 18, 'h13));
        put(i_type('h7ff, 2, 4, 19, 'h13));
        put(i_type(-256, 3, 6, 20, 'h13));
        put(i_type('hf0, 2, 7, 21, 'h13));
        put(u_type('h12345, 22, 'h17));
        for (int r = 4; r <= 22; r++)
            put(s_type((r - 4) * 8, r, 1));

        // Branch loop and jumps
        phase3_pc = `PC_RESET + 64'(4 * rom_len);
        put(i_type(3, 0, 0, 23, 'h13));
        put(i_type(5, 24, 0, 24, 'h13));
        put(i_type(-1, 23, 0, 23, 'h13));
        put(b_type(-8, 0, 23, 1));
        put(b_type(8, 0, 23, 0));
        put(i_type(99, 0, 0, 24, 'h13));
        put(b_type(8, 3, 2, 4));
        put(i_type(98, 0, 0, 24, 'h13));
        put(b_type(8, 3, 2, 6));
        put(i_type(7, 0, 0, 25, 'h13));
        put(b_type(8, 2, 3, 5));
        put(i_type(97, 0, 0, 25, 'h13));
        put(b_type(8, 3, 2, 7));
        put(i_type(96, 0, 0, 25, 'h13));
        put(j_type(8, 26));
        put(i_type(95, 0, 0, 25, 'h13));
        put(u_type(0, 27, 'h17));
        put(i_type(13, 27, 0, 28, 'h67));
        put(i_type(94, 0, 0, 25, 'h13));
        put(s_type(96, 24, 1));
        put(s_type(104, 25, 1));
        put(s_type(112, 26, 1));
        put(s_type(120, 28, 1));
        put(s_type(128, 27, 1));

        // Loads recombined and stored back
        phase4_pc = `PC_RESET + 64'(4 * rom_len);
        put(i_type(200, 1, 3, 29, 'h03));
        put(i_type(208, 1, 3, 30, 'h03));
        put(r_type(0, 30, 29, 0, 31));
        put(s_type(136, 31, 1));
        put(r_type(0, 30, 29, 4, 31));
        put(s_type(144, 31, 1));
        put(i_type(0, 1, 3, 29, 'h03));
        put(s_type(152, 29, 1));
        ebreak_pc = `PC_RESET + 64'(4 * rom_len);
        put(32'h0010_0073);

        repeat (8) @(posedge sys_clk);
        #1;
        rst = 1'b0;
        #4;
        check(1, pc == `PC_RESET, $sformatf("pc %h after reset", pc));
        check(1, !psel && !penable && !halted, "APB select, enable or halted high after reset");
        report_test(1);
        prev_pc = pc;
        running = 1'b1;

        cyc = 0;
        while (!halt_seen && cyc < 4000) begin
            @(posedge sys_clk);
            cyc++;
        end
        if (!halt_seen) begin
            $display("Timeout: the core did not reach EBREAK within 4000 cycles");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            check(4, wr_addr_q.size() == 0, "APB writes left over that no store explains");
            report_test(2);
            report_test(3);
            report_test(4);
            // Halted core must hold its pc
            repeat (20) begin
                @(posedge sys_clk);
                #5;
                check(5, halted && pc == ebreak_pc,
                      $sformatf("pc %h while halted, expected %h", pc, ebreak_pc));
            end
            report_test(5);
            total_chk = 0;
            total_err = 0;
            for (int i = 1; i <= 5; i++) begin
                total_chk += checks[i];
                total_err += errors[i];
            end
            $display("checks passed %0d, failed %0d", total_chk, total_err);
            if (total_err == 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule
